//--- build.sh
#!/usr/bin/env bash
# Compile and run the rvPipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module tbRvPipe \
    -f rvPipe.f \
    --Mdir obj_dir \
    -o simRvPipe
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simRvPipe > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- rvPipe.f
source/rvPipePkg.sv
source/memBusIf.sv
source/fetchUnit.sv
source/decodeUnit.sv
source/executeUnit.sv
source/memAccessUnit.sv
source/sharedMemory.sv
source/rvPipeTop.sv
testbench/rvPipeTop_properties.sv
testbench/tbRvPipe.sv

//--- source/decodeUnit.sv
// Register file, decode and ID/EX register
`timescale 1ns/10ps

module decodeUnit
    import rvPipePkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  wordT   ifInst,
    input  wordT   ifPc,
    input  logic   redirect,
    input  logic   wbWrite,
    input  regIdxT wbRd,
    input  wordT   wbData,
    input  regIdxT memRd,
    input  logic   memRegWrite,
    output logic   stall,
    output logic   exRegWrite,
    output logic   exMemRead,
    output logic   exMemWrite,
    output logic   exAluSrc,
    output logic   exBranch,
    output logic   exBranchNe,
    output aluOpT  exAluOp,
    output regIdxT exRd,
    output wordT   exRs1Data,
    output wordT   exRs2Data,
    output wordT   exImm,
    output wordT   exPc
);

    wordT regs [1:31];

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regIdxT     rs1, rs2, rd;
    wordT       rs1Data, rs2Data, imm;
    logic       regWrite, memRead, memWrite, aluSrc, branch, branchNe;
    logic       useRs1, useRs2, hazard1, hazard2;
    aluOpT      aluOp;

    assign opcode = ifInst[6:0];
    assign rd     = ifInst[11:7];
    assign funct3 = ifInst[14:12];
    assign rs1    = ifInst[19:15];
    assign rs2    = ifInst[24:20];
    assign funct7 = ifInst[31:25];

    always_ff @(posedge clk) begin
        if (wbWrite && wbRd != '0)
            regs[wbRd] <= wbData;
    end

    // Write-through read, x0 is zero
    always_comb begin
        rs1Data = '0;
        rs2Data = '0;
        if (rs1 != '0)
            rs1Data = (wbWrite && wbRd == rs1) ? wbData : regs[rs1];
        if (rs2 != '0)
            rs2Data = (wbWrite && wbRd == rs2) ? wbData : regs[rs2];
    end

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        useRs1   = 1'b0;
        useRs2   = 1'b0;
        aluOp    = aluAdd;
        imm      = {{20{ifInst[31]}}, ifInst[31:20]};
        case (opcode)
            opReg: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                regWrite = 1'b1;
                if (funct3 == f3AddSub && funct7 == f7Sub)
                    aluOp = aluSub;
                else if (funct3 == f3And && funct7 == f7Base)
                    aluOp = aluAnd;
                else if (funct3 == f3Or && funct7 == f7Base)
                    aluOp = aluOr;
                else if (funct3 == f3Xor && funct7 == f7Base)
                    aluOp = aluXor;
                else if (!(funct3 == f3AddSub && funct7 == f7Base)) begin
                    regWrite = 1'b0;   // Unsupported, NOP
                    useRs1 = 1'b0;
                    useRs2 = 1'b0;
                end
            end
            opImm: begin
                if (funct3 == f3AddSub) begin
                    regWrite = 1'b1;
                    aluSrc = 1'b1;
                    useRs1 = 1'b1;
                end
            end
            opLoad: begin
                if (funct3 == f3Word) begin
                    regWrite = 1'b1;
                    memRead = 1'b1;
                    aluSrc = 1'b1;
                    useRs1 = 1'b1;
                end
            end
            opStore: begin
                imm = {{20{ifInst[31]}}, ifInst[31:25], ifInst[11:7]};
                if (funct3 == f3Word) begin
                    memWrite = 1'b1;
                    aluSrc = 1'b1;
                    useRs1 = 1'b1;
                    useRs2 = 1'b1;
                end
            end
            opBranch: begin
                imm = {{19{ifInst[31]}}, ifInst[31], ifInst[7], ifInst[30:25],
                       ifInst[11:8], 1'b0};
                if (funct3 == f3Beq || funct3 == f3Bne) begin
                    branch = 1'b1;
                    branchNe = (funct3 == f3Bne);
                    useRs1 = 1'b1;
                    useRs2 = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // No forwarding, wait for writeback
    assign hazard1 = useRs1 && rs1 != '0 &&
                     ((exRegWrite && exRd == rs1) || (memRegWrite && memRd == rs1));
    assign hazard2 = useRs2 && rs2 != '0 &&
                     ((exRegWrite && exRd == rs2) || (memRegWrite && memRd == rs2));
    assign stall = hazard1 || hazard2;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exAluSrc   <= 1'b0;
            exBranch   <= 1'b0;
            exBranchNe <= 1'b0;
        end else if (redirect || stall) begin
            exRegWrite <= 1'b0;  // Bubble
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exAluSrc   <= 1'b0;
            exBranch   <= 1'b0;
            exBranchNe <= 1'b0;
        end else begin
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
            exAluSrc   <= aluSrc;
            exBranch   <= branch;
            exBranchNe <= branchNe;
        end
    end

    always_ff @(posedge clk) begin
        exAluOp   <= aluOp;
        exRd      <= rd;
        exRs1Data <= rs1Data;
        exRs2Data <= rs2Data;
        exImm     <= imm;
        exPc      <= ifPc;
    end

endmodule

//--- source/executeUnit.sv
// ALU, branch resolve and EX/MEM register
`timescale 1ns/10ps

module executeUnit
    import rvPipePkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  logic   exRegWrite,
    input  logic   exMemRead,
    input  logic   exMemWrite,
    input  logic   exAluSrc,
    input  logic   exBranch,
    input  logic   exBranchNe,
    input  aluOpT  exAluOp,
    input  regIdxT exRd,
    input  wordT   exRs1Data,
    input  wordT   exRs2Data,
    input  wordT   exImm,
    input  wordT   exPc,
    output logic   redirect,
    output wordT   target,
    output logic   memRegWrite,
    output logic   memMemRead,
    output logic   memMemWrite,
    output regIdxT memRd,
    output wordT   memResult,
    output wordT   memStoreData
);

    wordT aluB;
    wordT aluResult;
    logic equal;

    assign aluB = exAluSrc ? exImm : exRs2Data;

    always_comb begin
        case (exAluOp)
            aluSub:  aluResult = exRs1Data - aluB;
            aluAnd:  aluResult = exRs1Data & aluB;
            aluOr:   aluResult = exRs1Data | aluB;
            aluXor:  aluResult = exRs1Data ^ aluB;
            default: aluResult = exRs1Data + aluB;
        endcase
    end

    assign equal    = (exRs1Data == exRs2Data);
    assign redirect = exBranch && (exBranchNe ? !equal : equal);
    assign target   = exPc + exImm;   // Branch target

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        memRd        <= exRd;
        memResult    <= aluResult;
        memStoreData <= exRs2Data;
    end

endmodule

//--- source/fetchUnit.sv
// Instruction fetch stage
`timescale 1ns/10ps

module fetchUnit
    import rvPipePkg::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic run,
    input  logic stall,
    input  logic redirect,
    input  wordT target,
    memBusIf.requester bus,
    output wordT ifInst,
    output wordT ifPc
);

    wordT pc;

    assign bus.req   = run;
    assign bus.we    = 1'b0;
    assign bus.addr  = pc;
    assign bus.wdata = '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= resetPc;
            ifInst <= nopInst;
            ifPc   <= resetPc;
        end else if (redirect) begin
            pc     <= target;   // Kill the younger fetch
            ifInst <= nopInst;
        end else if (stall) begin
            // Hold IF/ID and PC
        end else if (run && bus.gnt) begin
            pc     <= pc + 32'd4;
            ifInst <= bus.rdata;
            ifPc   <= pc;
        end else begin
            ifInst <= nopInst;  // Lost grant or idle
        end
    end

endmodule

//--- source/memAccessUnit.sv
// Data access and MEM/WB register
`timescale 1ns/10ps

module memAccessUnit
    import rvPipePkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  logic   memRegWrite,
    input  logic   memMemRead,
    input  logic   memMemWrite,
    input  regIdxT memRd,
    input  wordT   memResult,
    input  wordT   memStoreData,
    memBusIf.requester bus,
    output logic   wbWrite,
    output regIdxT wbRd,
    output wordT   wbData
);

    assign bus.req   = memMemRead || memMemWrite;
    assign bus.we    = memMemWrite;
    assign bus.addr  = memResult;
    assign bus.wdata = memStoreData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            wbWrite <= 1'b0;
        else
            wbWrite <= memRegWrite && (!memMemRead || bus.gnt);  // Drop ungranted load
    end

    always_ff @(posedge clk) begin
        wbRd   <= memRd;
        wbData <= memMemRead ? bus.rdata : memResult;
    end

endmodule

//--- source/memBusIf.sv
// Requester port on the shared memory
`timescale 1ns/10ps

interface memBusIf
    import rvPipePkg::*;
();

    logic req;
    logic we;
    wordT addr;    // Byte address
    wordT wdata;
    wordT rdata;
    logic gnt;     // Same cycle as req

    modport requester (output req, we, addr, wdata, input rdata, gnt);
    modport memory (input req, we, addr, wdata, output rdata, gnt);

endinterface

//--- source/rvPipePkg.sv
// Core-wide types and constants
package rvPipePkg;

    typedef logic [31:0] wordT;    // Data, instruction or byte address
    typedef logic [4:0]  regIdxT;
    typedef logic [7:0]  memIdxT;  // Word index into the memory
    typedef logic [2:0]  aluOpT;

    // ALU operation codes
    localparam aluOpT aluAdd = 3'd0;
    localparam aluOpT aluSub = 3'd1;
    localparam aluOpT aluAnd = 3'd2;
    localparam aluOpT aluOr  = 3'd3;
    localparam aluOpT aluXor = 3'd4;

    localparam int memWords = 256;

    // ADDI x0,x0,0
    localparam wordT nopInst = 32'h0000_0013;
    localparam wordT resetPc = 32'h0000_0000;

    // Major opcodes
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    // funct3 and funct7 values of the supported subset
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;
    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Sub    = 7'b0100000;

endpackage

//--- source/rvPipeTop.sv
// Five-stage RV32I core top level
`timescale 1ns/10ps

module rvPipeTop
    import rvPipePkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  logic   run,
    input  logic   loadEn,
    input  memIdxT loadAddr,
    input  wordT   loadData,
    output logic   retireValid,
    output regIdxT retireRd,
    output wordT   retireData,
    output logic   memWrValid,
    output wordT   memWrAddr,
    output wordT   memWrData
);

    memBusIf fetchBus ();
    memBusIf dataBus ();

    wordT   ifInst, ifPc, target;
    logic   stall, redirect;
    logic   exRegWrite, exMemRead, exMemWrite, exAluSrc, exBranch, exBranchNe;
    aluOpT  exAluOp;
    regIdxT exRd, memRd, wbRd;
    wordT   exRs1Data, exRs2Data, exImm, exPc;
    logic   memRegWrite, memMemRead, memMemWrite, wbWrite;
    wordT   memResult, memStoreData, wbData;

    fetchUnit fetchUnit_inst (
        .clk, .arstN, .run, .stall, .redirect, .target,
        .bus(fetchBus), .ifInst, .ifPc
    );

    decodeUnit decodeUnit_inst (
        .clk, .arstN, .ifInst, .ifPc, .redirect, .wbWrite, .wbRd, .wbData,
        .memRd, .memRegWrite, .stall,
        .exRegWrite, .exMemRead, .exMemWrite, .exAluSrc, .exBranch, .exBranchNe,
        .exAluOp, .exRd, .exRs1Data, .exRs2Data, .exImm, .exPc
    );

    executeUnit executeUnit_inst (
        .clk, .arstN,
        .exRegWrite, .exMemRead, .exMemWrite, .exAluSrc, .exBranch, .exBranchNe,
        .exAluOp, .exRd, .exRs1Data, .exRs2Data, .exImm, .exPc,
        .redirect, .target,
        .memRegWrite, .memMemRead, .memMemWrite, .memRd, .memResult, .memStoreData
    );

    memAccessUnit memAccessUnit_inst (
        .clk, .arstN, .memRegWrite, .memMemRead, .memMemWrite, .memRd,
        .memResult, .memStoreData, .bus(dataBus), .wbWrite, .wbRd, .wbData
    );

    sharedMemory sharedMemory_inst (
        .clk, .arstN, .run, .loadEn, .loadAddr, .loadData,
        .fetchBus, .dataBus, .memWrValid, .memWrAddr, .memWrData
    );

    // x0 writes never retire
    assign retireValid = wbWrite && wbRd != '0;
    assign retireRd    = wbRd;
    assign retireData  = wbData;

endmodule

//--- source/sharedMemory.sv
// Unified memory with fixed-priority arbiter
`timescale 1ns/10ps

module sharedMemory
    import rvPipePkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  logic   run,
    input  logic   loadEn,
    input  memIdxT loadAddr,
    input  wordT   loadData,
    memBusIf.memory fetchBus,
    memBusIf.memory dataBus,
    output logic   memWrValid,
    output wordT   memWrAddr,
    output wordT   memWrData
);

    wordT mem [memWords];

    logic loadGo;
    wordT selAddr;
    wordT rdWord;

    // Loader, then data, then fetch
    assign loadGo       = loadEn && !run;
    assign dataBus.gnt  = dataBus.req && !loadGo;
    assign fetchBus.gnt = fetchBus.req && !loadGo && !dataBus.req;

    // One read port shared by both requesters
    assign selAddr        = dataBus.req ? dataBus.addr : fetchBus.addr;
    assign rdWord         = mem[selAddr[9:2]];
    assign dataBus.rdata  = rdWord;
    assign fetchBus.rdata = rdWord;

    assign memWrValid = dataBus.gnt && dataBus.we;
    assign memWrAddr  = dataBus.addr;
    assign memWrData  = dataBus.wdata;

    always_ff @(posedge clk) begin
        if (arstN) begin            // No writes while reset is held
            if (loadGo)
                mem[loadAddr] <= loadData;
            else if (memWrValid)
                mem[dataBus.addr[9:2]] <= dataBus.wdata;
        end
    end

endmodule

//--- testbench/rvPipeTop_properties.sv
// Arbitration and pipeline control checks
`timescale 1ns/10ps

module rvPipeTop_properties
    import rvPipePkg::*;
(
    input logic clk,
    input logic arstN,
    input logic fetchGnt,
    input logic dataReq,
    input logic dataGnt,
    input logic redirect,
    input wordT ifInst,
    input logic retireValid,
    input logic memWrValid
);

    // Single port, one winner per cycle
    oneGrant: assert property (@(posedge clk) disable iff (!arstN)
        !(fetchGnt && dataGnt))
        else $error("Fetch and data grants are high in the same cycle");

    dataGranted: assert property (@(posedge clk) disable iff (!arstN)
        dataReq |-> dataGnt)
        else $error("Data request was not granted");

    quietInReset: assert property (@(posedge clk)
        !arstN |-> (!retireValid && !memWrValid))
        else $error("Retire or store seen while reset is held");

    flushAfterRedirect: assert property (@(posedge clk) disable iff (!arstN)
        redirect |=> (ifInst == nopInst))
        else $error("IF/ID does not hold a NOP after a redirect");

endmodule

bind rvPipeTop rvPipeTop_properties rvPipeTop_properties_inst (
    .clk,
    .arstN,
    .fetchGnt(fetchBus.gnt),
    .dataReq(dataBus.req),
    .dataGnt(dataBus.gnt),
    .redirect,
    .ifInst,
    .retireValid,
    .memWrValid
);

//--- testbench/tbRvPipe.sv
// Pipelined core testbench
`timescale 1ns/10ps

module tbRvPipe
    import rvPipePkg::*;
();

    localparam int bodyLen     = 48;
    localparam int drainCycles = 20;

    logic   clk;
    logic   arstN;
    logic   run;
    logic   loadEn;
    memIdxT loadAddr;
    wordT   loadData;
    logic   retireValid;
    regIdxT retireRd;
    wordT   retireData;
    logic   memWrValid;
    wordT   memWrAddr;
    wordT   memWrData;

    wordT        img [memWords];   // Memory image, program then fill
    wordT        rngState;
    int          progLen;
    int          retireErrors;
    int          storeErrors;
    logic [36:0] expRetire [$];    // {rd, data}
    logic [63:0] expStore [$];     // {byte address, data}
    logic [36:0] nextRetire;
    logic [63:0] nextStore;

    rvPipeTop rvPipeTop_inst (.*);

    function automatic wordT xorshift(input wordT s);
        wordT x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic wordT encR(input logic [6:0] f7, input regIdxT rs2,
                                  input regIdxT rs1, input logic [2:0] f3,
                                  input regIdxT rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic wordT encI(input logic [11:0] imm, input regIdxT rs1,
                                  input logic [2:0] f3, input regIdxT rd,
                                  input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encS(input logic [11:0] imm, input regIdxT rs2,
                                  input regIdxT rs1);
        return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opStore};
    endfunction

    function automatic wordT encB(input logic [12:0] off, input regIdxT rs2,
                                  input regIdxT rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    task automatic genProgram();
        wordT        r;
        regIdxT      rd, rs1, rs2;
        logic [11:0] dataOff;
        int          n;
        int          i;
        n = 0;
        for (i = 1; i < 8; i++) begin
            rngState = xorshift(rngState);
            img[n] = encI(rngState[11:0], 5'd0, f3AddSub, i[4:0], opImm);
            n++;
        end
        img[n]     = encS(12'h300, 5'd1, 5'd0);   // Store then reload word 192
        img[n + 1] = encI(12'h300, 5'd0, f3Word, 5'd2, opLoad);
        img[n + 2] = encR(f7Base, 5'd2, 5'd1, f3AddSub, 5'd0);
        n += 3;
        for (i = 0; i < bodyLen; i++) begin
            rngState = xorshift(rngState);
            r = rngState;
            rd  = {2'b00, r[10:8]};
            rs1 = {2'b00, r[13:11]};
            rs2 = {2'b00, r[16:14]};
            dataOff = 12'h300 + {7'd0, r[31:29], 2'b00};   // Eight data words
            case (r[2:0])
                3'd0, 3'd1: begin
                    case (r[19:17])
                        3'd1:    img[n] = encR(f7Sub, rs2, rs1, f3AddSub, rd);
                        3'd2:    img[n] = encR(f7Base, rs2, rs1, f3And, rd);
                        3'd3:    img[n] = encR(f7Base, rs2, rs1, f3Or, rd);
                        3'd4:    img[n] = encR(f7Base, rs2, rs1, f3Xor, rd);
                        default: img[n] = encR(f7Base, rs2, rs1, f3AddSub, rd);
                    endcase
                end
                3'd3:    img[n] = encS(dataOff, rs2, 5'd0);
                3'd4:    img[n] = encI(dataOff, 5'd0, f3Word, rd, opLoad);
                3'd5:    img[n] = encB(13'd12, rs2, rs1, f3Beq);
                3'd6:    img[n] = encB(13'd12, rs2, rs1, f3Bne);
                default: img[n] = encI(r[28:17], rs1, f3AddSub, rd, opImm);
            endcase
            n++;
        end
        for (i = 0; i < 3; i++) begin
            img[n] = nopInst;   // Landing room for late branches
            n++;
        end
        img[n] = encB(13'd0, 5'd0, 5'd0, f3Beq);
        n++;
        progLen = n;
        for (i = n; i < memWords; i++)
            img[i] = {8'hD5, i[7:0], ~i[7:0], i[7:0]};
    endtask

    // ISA model, fills the expected retire and store lists
    task automatic runModel();
        wordT rf [32];
        wordT mdl [memWords];
        wordT pc, nextPc, inst, a, b, val, addr, selfLoop;
        wordT immI, immS, immB;
        logic wr;
        int   steps;
        int   i;
        for (i = 0; i < 32; i++)
            rf[i] = '0;
        for (i = 0; i < memWords; i++)
            mdl[i] = img[i];
        selfLoop = encB(13'd0, 5'd0, 5'd0, f3Beq);
        pc = resetPc;
        steps = 0;
        while (mdl[pc[9:2]] != selfLoop && steps < 4 * memWords) begin
            inst   = mdl[pc[9:2]];
            a      = rf[inst[19:15]];
            b      = rf[inst[24:20]];
            immI   = {{20{inst[31]}}, inst[31:20]};
            immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            immB   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            nextPc = pc + 32'd4;
            wr     = 1'b0;
            val    = '0;
            case (inst[6:0])
                opReg: begin
                    wr = 1'b1;
                    case (inst[14:12])
                        f3Xor:   val = a ^ b;
                        f3Or:    val = a | b;
                        f3And:   val = a & b;
                        default: val = inst[30] ? a - b : a + b;
                    endcase
                end
                opImm: begin
                    wr = 1'b1;
                    val = a + immI;
                end
                opLoad: begin
                    wr = 1'b1;
                    addr = a + immI;
                    val = mdl[addr[9:2]];
                end
                opStore: begin
                    addr = a + immS;
                    mdl[addr[9:2]] = b;
                    expStore.push_back({addr, b});
                end
                opBranch: begin
                    if ((a == b) != inst[12])   // funct3 bit 0 selects BNE
                        nextPc = pc + immB;
                end
                default: ;
            endcase
            if (wr && inst[11:7] != 5'd0) begin
                rf[inst[11:7]] = val;
                expRetire.push_back({inst[11:7], val});
            end
            pc = nextPc;
            steps++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (retireValid) begin
            assert (run)
            else begin
                retireErrors++;
                $display("Retire of x%0d at %0t ns before run was raised", retireRd, $time);
            end
            assert (expRetire.size() > 0)
            else begin
                retireErrors++;
                $display("Retire of x%0d at %0t ns that the model does not expect",
                         retireRd, $time);
            end
            if (expRetire.size() > 0) begin
                nextRetire = expRetire.pop_front();
                assert (retireRd == nextRetire[36:32])
                else begin
                    retireErrors++;
                    $display("error at %0t ns: retireRd expected %0d actual %0d",
                             $time, nextRetire[36:32], retireRd);
                end
                assert (retireData == nextRetire[31:0])
                else begin
                    retireErrors++;
                    $display("error at %0t ns: retireData expected %h actual %h",
                             $time, nextRetire[31:0], retireData);
                end
            end
        end
        if (memWrValid) begin
            assert (run && expStore.size() > 0)
            else begin
                storeErrors++;
                $display("Store to %h at %0t ns that the model does not expect",
                         memWrAddr, $time);
            end
            if (expStore.size() > 0) begin
                nextStore = expStore.pop_front();
                assert (memWrAddr == nextStore[63:32])
                else begin
                    storeErrors++;
                    $display("error at %0t ns: memWrAddr expected %h actual %h",
                             $time, nextStore[63:32], memWrAddr);
                end
                assert (memWrData == nextStore[31:0])
                else begin
                    storeErrors++;
                    $display("error at %0t ns: memWrData expected %h actual %h",
                             $time, nextStore[31:0], memWrData);
                end
            end
        end
    end

    initial begin
        int   cycles;
        int   limit;
        int   i;
        logic timedOut;
        arstN    = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        retireErrors = 0;
        storeErrors  = 0;
        rngState = 32'h8df9;
        genProgram();
        runModel();
        limit = 12 * progLen + 200;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        for (i = 0; i < memWords; i++) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = i[7:0];
            loadData = img[i];
        end
        @(negedge clk);
        loadEn = 1'b0;
        repeat (4) @(negedge clk);   // Idle, nothing may retire
        run = 1'b1;
        cycles = 0;
        while ((expRetire.size() > 0 || expStore.size() > 0) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        timedOut = (cycles >= limit);
        repeat (drainCycles) @(negedge clk);   // Catch extra retires in the self-loop
        if (timedOut)
            $display("Timeout after %0d cycles with %0d retires and %0d stores never seen",
                     cycles, expRetire.size(), expStore.size());
        $display("Errors: retire %0d, store %0d, timeout %0d",
                 retireErrors, storeErrors, timedOut);
        if (retireErrors == 0 && storeErrors == 0 && !timedOut) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
